/* i2s_pkg.sv */
// I2S receiver shared types: channel select, synchronized pin view, word and stereo frame
package i2s_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Every sample sits left-aligned in a container of this width
    // Also the upper bound for SAMPLE_WIDTH
    localparam int SAMPLE_CONTAINER_WIDTH = 32;

    ////////////////////////////////////////
    // Channel select
    ////////////////////////////////////////

    // Word select low is the left slot, high is the right slot
    typedef enum logic {
        LEFT  = 1'b0,
        RIGHT = 1'b1
    } channel_e;

    ////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////

    // Pin view after synchronization, 3 bits
    typedef struct packed {
        logic sck_rise;     // One clk pulse per serial clock rising edge
        logic sd;           // Delayed serial data
        logic ws;           // Delayed word select
    } i2s_line_t;

    // One received slot, 33 bits
    // Data is left-aligned, low bits past SAMPLE_WIDTH are zero
    typedef struct packed {
        channel_e                          channel;
        logic [SAMPLE_CONTAINER_WIDTH-1:0] data;
    } i2s_word_t;

    // Left and right pair, 64 bits
    typedef struct packed {
        logic [SAMPLE_CONTAINER_WIDTH-1:0] left;
        logic [SAMPLE_CONTAINER_WIDTH-1:0] right;
    } stereo_frame_t;

endpackage

/* i2s_sync.sv */
// I2S pin synchronizer with serial clock rising edge detection and matched data delay
`timescale 1ns/10ps

module i2s_sync
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sck_raw,
    input  logic              sd_raw,
    input  logic              ws_raw,
    output i2s_pkg::i2s_line_t line
);

    ////////////////////////////////////////
    // Synchronizer chains
    ////////////////////////////////////////

    // sck_vec[1] is the synchronized clock
    // sck_vec[2] holds its previous value for edge detection
    logic [2:0] sck_vec;

    // Data and word select run one flop deeper so a sample
    // taken at the rising edge is well away from codec falling-edge changes
    logic [3:0] sd_vec;
    logic [3:0] ws_vec;

    // Registered edge flag
    logic       sck_rise_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_vec    <= '0;
            sd_vec     <= '0;
            ws_vec     <= '0;
            sck_rise_q <= 1'b0;
        end
        else
        begin
            // Shift each pin one flop per clk
            sck_vec <= {sck_vec[1:0], sck_raw};
            sd_vec  <= {sd_vec[2:0], sd_raw};
            ws_vec  <= {ws_vec[2:0], ws_raw};

            // Synchronized high, previous low: rising edge
            sck_rise_q <= sck_vec[1] & ~sck_vec[2];
        end
    end

    // Outputs straight from flops
    assign line.sck_rise = sck_rise_q;
    assign line.sd       = sd_vec[3];
    assign line.ws       = ws_vec[3];

endmodule

/* i2s_deserializer.sv */
// I2S deserializer: shifts serial data MSB first and emits one word per completed slot
`timescale 1ns/10ps

module i2s_deserializer
#(
    parameter int SAMPLE_WIDTH = 24
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  i2s_pkg::i2s_line_t line,
    output logic               word_valid,
    output i2s_pkg::i2s_word_t word
);

    ////////////////////////////////////////
    // Local sizes
    ////////////////////////////////////////

    localparam int CW = i2s_pkg::SAMPLE_CONTAINER_WIDTH;

    // Counter spans 0 to SAMPLE_WIDTH inclusive
    localparam int CNT_W = $clog2(SAMPLE_WIDTH + 1);

    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SAMPLE_WIDTH);

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    // Word select seen at the last serial clock rise
    logic             ws_prev;

    // Set at the first word select change after reset
    logic             aligned;

    // Bits stored in this slot, stops at SAMPLE_WIDTH
    logic [CNT_W-1:0] bit_cnt;

    // Slot data, filled from bit CW-1 downward
    logic [CW-1:0]    shreg;

    // Slot data with the current bit merged in
    logic [CW-1:0]    data_next;

    // Current bit still fits within SAMPLE_WIDTH
    logic             bit_take;

    // Word select moved since the last rise
    logic             ws_change;

    ////////////////////////////////////////
    // Next slot data
    ////////////////////////////////////////

    assign bit_take  = (bit_cnt < CNT_MAX);
    assign ws_change = (line.ws != ws_prev);

    always_comb
    begin
        data_next = shreg;
        // Bits past SAMPLE_WIDTH are dropped, which truncates long slots
        if (bit_take)
        begin
            data_next[CW - 1 - int'(bit_cnt)] = line.sd;
        end
    end

    ////////////////////////////////////////
    // Control path
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_prev    <= 1'b0;
            aligned    <= 1'b0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            // Strobe lasts one cycle
            word_valid <= 1'b0;

            if (line.sck_rise)
            begin
                ws_prev <= line.ws;

                if (ws_change)
                begin
                    // Bit sampled now closes the previous slot
                    word_valid <= aligned;
                    aligned    <= 1'b1;
                    bit_cnt    <= '0;
                end
                else if (bit_take)
                begin
                    bit_cnt <= bit_cnt + CNT_W'(1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (line.sck_rise)
        begin
            if (ws_change)
            begin
                // Old word select names the finished slot
                word.channel <= i2s_pkg::channel_e'(ws_prev);
                word.data    <= data_next;
                // Empty register so short slots pad with zeros
                shreg        <= '0;
            end
            else
            begin
                shreg <= data_next;
            end
        end
    end

endmodule

/* i2s_frame_assembler.sv */
// Stereo frame assembler: pairs a stored left word with the following right word
`timescale 1ns/10ps

module i2s_frame_assembler
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  i2s_pkg::i2s_word_t     word,
    output logic                   frame_valid,
    output i2s_pkg::stereo_frame_t frame
);

    ////////////////////////////////////////
    // Left word holding
    ////////////////////////////////////////

    localparam int CW = i2s_pkg::SAMPLE_CONTAINER_WIDTH;

    // Last left sample seen
    logic [CW-1:0] left_q;

    // Left sample waiting for its right partner
    logic          pending;

    // Word type decode
    logic          is_left;
    logic          is_right;

    assign is_left  = word_valid && (word.channel == i2s_pkg::LEFT);
    assign is_right = word_valid && (word.channel == i2s_pkg::RIGHT);

    // A newer left word simply overwrites the older one
    always_ff @(posedge clk)
    begin
        if (is_left)
        begin
            left_q <= word.data;
        end
    end

    ////////////////////////////////////////
    // Pairing and output
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending     <= 1'b0;
            frame_valid <= 1'b0;
            frame       <= '0;
        end
        else
        begin
            // One-cycle strobe
            frame_valid <= 1'b0;

            if (is_left)
            begin
                pending <= 1'b1;
            end
            else if (is_right)
            begin
                // Right word without a stored left word is dropped
                if (pending)
                begin
                    frame.left  <= left_q;
                    frame.right <= word.data;
                    frame_valid <= 1'b1;
                end
                pending <= 1'b0;
            end
        end
    end

endmodule

/* i2s_rx_top.sv */
// I2S receiver top: synchronizer, deserializer and frame assembler in series
`timescale 1ns/10ps

module i2s_rx_top
#(
    // Bits kept per slot, 8 to 32
    parameter int SAMPLE_WIDTH = 24
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck_raw,
    input  logic                   sd_raw,
    input  logic                   ws_raw,
    output logic                   frame_valid,
    output i2s_pkg::stereo_frame_t frame
);

    ////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////

    i2s_pkg::i2s_line_t line;
    logic               word_valid;
    i2s_pkg::i2s_word_t word;

    // Pins into clk domain, edge pulse out
    i2s_sync sync_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sck_raw (sck_raw),
        .sd_raw  (sd_raw),
        .ws_raw  (ws_raw),
        .line    (line)
    );

    // Serial bits to left-aligned words
    i2s_deserializer #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) deser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .line       (line),
        .word_valid (word_valid),
        .word       (word)
    );

    // Left and right words to stereo frames
    i2s_frame_assembler asm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .word_valid  (word_valid),
        .word        (word),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and power-on reset source, 8 ns clock with reset held for 10 cycles
`timescale 1ns/10ps

module tb_clock_gen
#(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's active edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* i2s_rx_tb.sv */
// I2S receiver testbench: codec model, reference model and frame checker
`timescale 1ns/10ps

module i2s_rx_tb;

    localparam int SAMPLE_WIDTH = 24;
    localparam int DRAIN_LIMIT  = 2000;

    logic                   clk;
    logic                   por_n;
    logic                   mid_rst_n;
    logic                   rst_n;
    logic                   sck_raw;
    logic                   sd_raw;
    logic                   ws_raw;
    logic                   frame_valid;
    i2s_pkg::stereo_frame_t frame;

    // Expected frames in arrival order
    i2s_pkg::stereo_frame_t exp_q[$];

    logic [31:0] rng_state;
    // LSB of the previous slot, sent in the first bit after a word select change
    logic        carry_bit;
    int          mismatches;
    int          unexpected;
    int          timeouts;
    int          checked;

    // Power-on reset combined with the mid-stream reset
    assign rst_n = por_n & mid_rst_n;

    tb_clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (por_n)
    );

    i2s_rx_top #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck_raw     (sck_raw),
        .sd_raw      (sd_raw),
        .ws_raw      (ws_raw),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Low n bits set
    function automatic logic [31:0] slot_mask(input int n);
        return (n >= 32) ? 32'hFFFF_FFFF : ((32'h1 << n) - 32'h1);
    endfunction

    // Sample left-aligned, then cut to SAMPLE_WIDTH bits from the top
    function automatic logic [31:0] expected_sample(input logic [31:0] v, input int n);
        logic [31:0] aligned;
        logic [31:0] mask;
        int          keep;
        aligned = v << (32 - n);
        keep    = (n < SAMPLE_WIDTH) ? n : SAMPLE_WIDTH;
        mask    = 32'hFFFF_FFFF << (32 - keep);
        return aligned & mask;
    endfunction

    function automatic i2s_pkg::stereo_frame_t expected_frame(
        input logic [31:0] l,
        input logic [31:0] r,
        input int          n
    );
        i2s_pkg::stereo_frame_t f;
        f.left  = expected_sample(l, n);
        f.right = expected_sample(r, n);
        return f;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic compare_frame(
        input string                  name,
        input i2s_pkg::stereo_frame_t got,
        input i2s_pkg::stereo_frame_t exp
    );
        if (got.left !== exp.left)
        begin
            mismatches++;
            $display("FAILED t=%0t %s.left got=%h exp=%h", $time, name, got.left, exp.left);
        end
        if (got.right !== exp.right)
        begin
            mismatches++;
            $display("FAILED t=%0t %s.right got=%h exp=%h", $time, name, got.right, exp.right);
        end
    endtask

    ////////////////////////////////////////
    // Codec model
    ////////////////////////////////////////

    // One serial clock period, 4 clk low then 4 clk high
    task automatic send_bit(input logic ws, input logic sd);
        @(negedge clk);
        sck_raw = 1'b0;
        ws_raw  = ws;
        sd_raw  = sd;
        repeat (4) @(negedge clk);
        sck_raw = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    // First bit carries the previous LSB, then MSB first
    task automatic send_slot(input i2s_pkg::channel_e ch, input logic [31:0] value, input int n);
        logic [31:0] shifted;
        for (int i = 0; i < n; i++)
        begin
            shifted = value >> (n - i);
            send_bit(ch, (i == 0) ? carry_bit : shifted[0]);
        end
        carry_bit = value[0];
    endtask

    task automatic next_sample(input int n, output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state & slot_mask(n);
    endtask

    task automatic send_frame(input int n, input logic check);
        logic [31:0] l;
        logic [31:0] r;
        next_sample(n, l);
        next_sample(n, r);
        send_slot(i2s_pkg::LEFT, l, n);
        send_slot(i2s_pkg::RIGHT, r, n);
        // Right word leaves when the next left slot begins
        if (check)
        begin
            exp_q.push_back(expected_frame(l, r, n));
        end
    endtask

    ////////////////////////////////////////
    // Waits and reset checks
    ////////////////////////////////////////

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < DRAIN_LIMIT)
        begin
            @(negedge clk);
            cnt++;
        end
        if (exp_q.size() != 0)
        begin
            timeouts++;
            $display("Timeout at t=%0t: %0d expected frames never came on frame_valid",
                     $time, exp_q.size());
            exp_q.delete();
        end
        // Idle a while so stray frames still show up
        repeat (40) @(negedge clk);
    endtask

    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (!rst_n && cnt < 100)
        begin
            @(negedge clk);
            cnt++;
        end
        if (!rst_n)
        begin
            timeouts++;
            $display("Timeout at t=%0t: reset was never released", $time);
        end
    endtask

    // Outputs quiet and cleared after reset
    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            compare_bit("frame_valid", frame_valid, 1'b0);
            compare_frame("frame", frame, '0);
        end
    endtask

    ////////////////////////////////////////
    // Frame checker
    ////////////////////////////////////////

    initial
    begin : frame_check
        i2s_pkg::stereo_frame_t exp;
        forever
        begin
            @(negedge clk);
            if (rst_n && frame_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    unexpected++;
                    $display("Unexpected frame at t=%0t with no frame outstanding", $time);
                end
                else
                begin
                    exp = exp_q.pop_front();
                    compare_frame("frame", frame, exp);
                    checked++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin : main_seq
        logic [31:0] junk;
        sck_raw    = 1'b0;
        sd_raw     = 1'b0;
        ws_raw     = 1'b0;
        mid_rst_n  = 1'b1;
        carry_bit  = 1'b0;
        rng_state  = 32'h722236e5;
        mismatches = 0;
        unexpected = 0;
        timeouts   = 0;
        checked    = 0;

        wait_reset_release();
        check_idle(5);

        // Lead frame is not framed by a word select change
        send_frame(32, 1'b0);
        repeat (8) send_frame(32, 1'b1);
        repeat (6) send_frame(24, 1'b1);
        repeat (6) send_frame(16, 1'b1);
        repeat (3) send_frame(32, 1'b1);

        // Half a frame, then reset in the right slot
        next_sample(32, junk);
        send_slot(i2s_pkg::LEFT, junk, 32);
        next_sample(8, junk);
        send_slot(i2s_pkg::RIGHT, junk, 8);
        wait_drain();
        @(negedge clk);
        mid_rst_n = 1'b0;
        sck_raw   = 1'b0;
        repeat (10) @(negedge clk);
        mid_rst_n = 1'b1;
        check_idle(5);

        // Right slot still running when reset ends, so it is never emitted
        next_sample(8, junk);
        send_slot(i2s_pkg::RIGHT, junk, 8);
        repeat (6) send_frame(32, 1'b1);

        // Word select change closes the last right slot
        send_bit(1'b0, carry_bit);
        wait_drain();

        $display("Errors: mismatches=%0d unexpected=%0d timeouts=%0d, frames checked=%0d",
                 mismatches, unexpected, timeouts, checked);
        if (mismatches + unexpected + timeouts == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
i2s_pkg.sv
i2s_sync.sv
i2s_deserializer.sv
i2s_frame_assembler.sv
i2s_rx_top.sv
tb_clock_gen.sv
i2s_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I2S receiver simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f filelist.f --top-module i2s_rx_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/Vi2s_rx_tb 2>&1); then
    echo "$sim_out"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
